// File: line_buffer_cfg.svh
`ifndef LINE_BUFFER_CFG_SVH
`define LINE_BUFFER_CFG_SVH

// --------------------
// pixel format
// --------------------

// bits per pixel
`define LB_PIX_BITS 8

// --------------------
// line geometry
// --------------------

// column address width, covers the longest line
`define LB_COL_BITS 6

// longest line the row buffer can hold
`define LB_MAX_COLS 64

// shortest legal line, write-back lands two cycles after the read
`define LB_MIN_COLS 3

`endif

// File: video_pkg.sv
`default_nettype none

`include "line_buffer_cfg.svh"

package video_pkg;

    // --------------------
    // pixel stream
    // --------------------

    // one pixel of the raster
    typedef logic [`LB_PIX_BITS-1:0] pixel_t;

    // one input beat, strobes only, no handshake
    typedef struct packed {
        // beat carries a pixel
        logic   valid;
        // first pixel of a frame, implies sol
        logic   sof;
        // first pixel of a line
        logic   sol;
        pixel_t data;
    } pixel_beat_t;

endpackage

`default_nettype wire

// File: window_pkg.sv
`default_nettype none

`include "line_buffer_cfg.svh"

package window_pkg;

    // --------------------
    // raster position
    // --------------------

    // column address into the row buffer
    typedef logic [`LB_COL_BITS-1:0] col_t;

    // row_lvl saturates at 2: first line, second line, any later line
    typedef struct packed {
        col_t       col;
        logic [1:0] row_lvl;
    } line_pos_t;

    // --------------------
    // row buffer word
    // --------------------

    // both older rows side by side in one RAM word
    typedef struct packed {
        video_pkg::pixel_t up1;
        video_pkg::pixel_t up2;
    } row_pair_t;

    // vertical 3-tap window
    typedef struct packed {
        logic              valid;
        col_t              col;
        video_pkg::pixel_t cur;
        video_pkg::pixel_t up1;
        video_pkg::pixel_t up2;
        logic              up1_ok;
        logic              up2_ok;
    } window_t;

endpackage

`default_nettype wire

// File: ram_simple_dualport.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_buffer_cfg.svh"

// simple dual-port RAM, one word per column
module ram_simple_dualport #(
    parameter int DATA_WIDTH = 16,
    parameter bit DOUT_REGS  = 0,
    parameter     RAM_TYPE   = "distributed"
) (
    // write port
    input  var logic                    wr_clk,
    input  var logic                    wr_en,
    input  var window_pkg::col_t        wr_addr,
    input  var logic [DATA_WIDTH-1:0]   wr_din,

    // read port
    input  var logic                    rd_clk,
    input  var logic                    rd_en,
    input  var logic                    rd_regcke,
    input  var window_pkg::col_t        rd_addr,
    output var logic [DATA_WIDTH-1:0]   rd_dout
);

    localparam int MEM_SIZE = `LB_MAX_COLS;

    // --------------------
    // storage
    // --------------------

    (* ram_style = RAM_TYPE *)
    logic [DATA_WIDTH-1:0] mem [0:MEM_SIZE-1];

    // first read stage
    logic [DATA_WIDTH-1:0] rd_data;

    // write port
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_din;
        end
    end

    // registered read, old word on a same-edge collision
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // --------------------
    // output stage
    // --------------------

    generate
        if (DOUT_REGS) begin : g_dout_reg
            logic [DATA_WIDTH-1:0] dout_q;

            // second stage, advanced one cycle after the read
            always_ff @(posedge rd_clk) begin
                if (rd_regcke) begin
                    dout_q <= rd_data;
                end
            end

            assign rd_dout = dout_q;
        end else begin : g_dout_direct
            assign rd_dout = rd_data;
        end
    endgenerate

    // --------------------
    // checks
    // --------------------

    // writes must stay inside the row buffer
    a_wr_addr_range: assert property (
        @(posedge wr_clk) wr_en |-> (int'(wr_addr) < MEM_SIZE)
    ) else $error("write address %0d outside row buffer", wr_addr);

endmodule

`default_nettype wire

// File: line_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_buffer_cfg.svh"

// tracks column and row level and issues one RAM read per pixel
module line_read_ctrl (
    input  var logic                    rd_clk,
    input  var logic                    reset,
    input  var video_pkg::pixel_beat_t  s_beat,
    output var logic                    rd_en,
    output var window_pkg::col_t        rd_addr,
    output var logic                    rd_valid,
    output var window_pkg::line_pos_t   rd_pos,
    output var video_pkg::pixel_t       rd_pix
);

    import window_pkg::*;

    // one extra bit so a full line can be counted
    localparam int LEN_BITS = `LB_COL_BITS + 1;

    logic                line_start;
    logic [LEN_BITS-1:0] line_len;
    logic [1:0]          row_lvl;
    line_pos_t           beat_pos;

    // --------------------
    // position tracking
    // --------------------

    // sof implies sol, either one opens a line
    assign line_start = s_beat.sol | s_beat.sof;

    // place of the incoming beat in the raster
    always_comb begin
        beat_pos.col = line_start ? '0 : line_len[`LB_COL_BITS-1:0];
        if (s_beat.sof) begin
            beat_pos.row_lvl = 2'd0;
        end else if (line_start && (row_lvl != 2'd2)) begin
            beat_pos.row_lvl = row_lvl + 2'd1;
        end else begin
            beat_pos.row_lvl = row_lvl;
        end
    end

    // pixel count of the current line and its row level
    always_ff @(posedge rd_clk) begin
        if (reset) begin
            line_len <= '0;
            row_lvl  <= 2'd0;
        end else if (s_beat.valid) begin
            line_len <= LEN_BITS'(beat_pos.col) + LEN_BITS'(1);
            row_lvl  <= beat_pos.row_lvl;
        end
    end

    // --------------------
    // read issue
    // --------------------

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            rd_en    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_en    <= s_beat.valid;
            rd_valid <= s_beat.valid;
        end
    end

    // address and payload travel with the read strobe
    always_ff @(posedge rd_clk) begin
        rd_addr <= beat_pos.col;
        rd_pos  <= beat_pos;
        rd_pix  <= s_beat.data;
    end

    // --------------------
    // checks
    // --------------------

    // column must stay inside the row buffer
    a_col_range: assert property (
        @(posedge rd_clk) disable iff (reset)
        (s_beat.valid && !line_start) |-> (line_len < LEN_BITS'(`LB_MAX_COLS))
    ) else $error("line longer than %0d pixels", `LB_MAX_COLS);

    // short lines would let the next read overtake the write-back
    a_min_line: assert property (
        @(posedge rd_clk) disable iff (reset)
        (s_beat.valid && line_start && (line_len != '0))
            |-> (line_len >= LEN_BITS'(`LB_MIN_COLS))
    ) else $error("line of %0d pixels is below the minimum", line_len);

endmodule

`default_nettype wire

// File: window_assembler.sv
`timescale 1ns/1ps
`default_nettype none

// aligns the pixel with the read data, forms the window, writes the row pair back
module window_assembler (
    input  var logic                    rd_clk,
    input  var logic                    reset,
    input  var logic                    rd_valid,
    input  var window_pkg::line_pos_t   rd_pos,
    input  var video_pkg::pixel_t       rd_pix,
    input  var window_pkg::row_pair_t   rd_dout,
    output var logic                    rd_regcke,
    output var logic                    wr_en,
    output var window_pkg::col_t        wr_addr,
    output var window_pkg::row_pair_t   wr_din,
    output var window_pkg::window_t     m_win
);

    import video_pkg::*;
    import window_pkg::*;

    logic      s1_valid;
    logic      s2_valid;
    logic      win_valid;
    line_pos_t s1_pos;
    line_pos_t s2_pos;
    pixel_t    s1_pix;
    pixel_t    s2_pix;
    window_t   win_d;
    window_t   win_q;

    // --------------------
    // alignment pipeline
    // --------------------

    // stage 1 covers the RAM read and stage 2 the output register
    always_ff @(posedge rd_clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            s1_valid  <= rd_valid;
            s2_valid  <= s1_valid;
            win_valid <= s2_valid;
        end
    end

    always_ff @(posedge rd_clk) begin
        s1_pos <= rd_pos;
        s1_pix <= rd_pix;
        s2_pos <= s1_pos;
        s2_pix <= s1_pix;
        win_q  <= win_d;
    end

    // RAM output register follows the read by one cycle
    assign rd_regcke = s1_valid;

    // --------------------
    // window forming
    // --------------------

    // rows not yet seen in this frame read as zero
    always_comb begin
        win_d        = '0;
        win_d.col    = s2_pos.col;
        win_d.cur    = s2_pix;
        win_d.up1_ok = (s2_pos.row_lvl != 2'd0);
        win_d.up2_ok = (s2_pos.row_lvl == 2'd2);
        win_d.up1    = win_d.up1_ok ? rd_dout.up1 : '0;
        win_d.up2    = win_d.up2_ok ? rd_dout.up2 : '0;
    end

    always_comb begin
        m_win       = win_q;
        m_win.valid = win_valid;
    end

    // current pixel moves to up1 and old up1 to up2
    assign wr_en      = s2_valid;
    assign wr_addr    = s2_pos.col;
    assign wr_din.up1 = s2_pix;
    assign wr_din.up2 = win_d.up1;

    // --------------------
    // checks
    // --------------------

    // a read must not reach a column whose write-back is still in flight
    a_write_before_reread: assert property (
        @(posedge rd_clk) disable iff (reset)
        rd_valid |-> !((s1_valid && (s1_pos.col == rd_pos.col))
                       || (s2_valid && (s2_pos.col == rd_pos.col)))
    ) else $error("read of column %0d overtakes its write-back", rd_pos.col);

endmodule

`default_nettype wire

// File: vertical_window_top.sv
`timescale 1ns/1ps
`default_nettype none

// vertical 3-tap window generator
module vertical_window_top (
    input  var logic                    rd_clk,
    input  var logic                    reset,
    input  var video_pkg::pixel_beat_t  s_beat,
    output var window_pkg::window_t     m_win
);

    import video_pkg::*;
    import window_pkg::*;

    // read side
    logic      rd_en;
    col_t      rd_addr;
    logic      rd_valid;
    line_pos_t rd_pos;
    pixel_t    rd_pix;
    logic      rd_regcke;
    row_pair_t rd_dout;

    // write-back side
    logic      wr_en;
    col_t      wr_addr;
    row_pair_t wr_din;

    // --------------------
    // producer
    // --------------------

    line_read_ctrl u_ctrl (
        .rd_clk   (rd_clk),
        .reset    (reset),
        .s_beat   (s_beat),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_pos   (rd_pos),
        .rd_pix   (rd_pix)
    );

    // --------------------
    // row buffer
    // --------------------

    // single clock domain, write port shares rd_clk
    ram_simple_dualport #(
        .DATA_WIDTH ($bits(row_pair_t)),
        .DOUT_REGS  (1'b1),
        .RAM_TYPE   ("distributed")
    ) u_ram (
        .wr_clk    (rd_clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_din    (wr_din),
        .rd_clk    (rd_clk),
        .rd_en     (rd_en),
        .rd_regcke (rd_regcke),
        .rd_addr   (rd_addr),
        .rd_dout   (rd_dout)
    );

    // --------------------
    // consumer
    // --------------------

    window_assembler u_asm (
        .rd_clk    (rd_clk),
        .reset     (reset),
        .rd_valid  (rd_valid),
        .rd_pos    (rd_pos),
        .rd_pix    (rd_pix),
        .rd_dout   (rd_dout),
        .rd_regcke (rd_regcke),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_din    (wr_din),
        .m_win     (m_win)
    );

endmodule

`default_nettype wire

// File: tb_vertical_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_buffer_cfg.svh"

module tb_vertical_window;

    import video_pkg::*;
    import window_pkg::*;

    logic        rd_clk;
    logic        reset;
    pixel_beat_t s_beat;
    window_t     m_win;

    integer seed = 32'hddc9f6d4;
    int     errors;
    int     neg_cnt;
    int     in_cnt;
    int     win_cnt;

    // reference model, last two lines per column
    pixel_t  row1 [0:`LB_MAX_COLS-1];
    pixel_t  row2 [0:`LB_MAX_COLS-1];
    int      ref_col;
    int      ref_lvl;
    window_t exp_q [$];
    int      beat_q [$];

    vertical_window_top uut (
        .rd_clk (rd_clk),
        .reset  (reset),
        .s_beat (s_beat),
        .m_win  (m_win)
    );

    always #2 rd_clk = ~rd_clk;

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
        end
    endtask

    task automatic check_window(input window_t exp, input window_t act);
        if (act.valid !== exp.valid) begin
            errors++;
            $display("FAILED at %0t: m_win.valid expected %b, got %b",
                     $time, exp.valid, act.valid);
        end
        if (act.col !== exp.col) begin
            errors++;
            $display("FAILED at %0t: m_win.col expected %0d, got %0d", $time, exp.col, act.col);
        end
        if (act.up1_ok !== exp.up1_ok) begin
            errors++;
            $display("FAILED at %0t: m_win.up1_ok expected %b, got %b",
                     $time, exp.up1_ok, act.up1_ok);
        end
        if (act.up2_ok !== exp.up2_ok) begin
            errors++;
            $display("FAILED at %0t: m_win.up2_ok expected %b, got %b",
                     $time, exp.up2_ok, act.up2_ok);
        end
        check_pixel("m_win.cur", exp.cur, act.cur);
        check_pixel("m_win.up1", exp.up1, act.up1);
        check_pixel("m_win.up2", exp.up2, act.up2);
    endtask

    task automatic check_latency(input int beat_cyc, input int win_cyc);
        if (win_cyc - beat_cyc != 3) begin
            errors++;
            $display("at %0t a window arrived %0d cycles after its beat instead of 3",
                     $time, win_cyc - beat_cyc);
        end
    endtask

    // --------------------
    // output monitor
    // --------------------

    // a beat seen at negedge k is taken at the following posedge
    always @(negedge rd_clk) begin
        neg_cnt = neg_cnt + 1;
        if (!reset && s_beat.valid) begin
            beat_q.push_back(neg_cnt + 1);
        end
        if (!reset && m_win.valid) begin
            win_cnt++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("at %0t a window appeared without a matching beat", $time);
            end else begin
                check_window(exp_q.pop_front(), m_win);
            end
            if (beat_q.size() != 0) begin
                check_latency(beat_q.pop_front(), neg_cnt);
            end
        end
    end

    // --------------------
    // stimulus and model
    // --------------------

    // window expected from one beat, then shift the stored rows
    task automatic predict_window(input bit sof, input bit sol, input pixel_t data);
        window_t w;
        if (sof) begin
            ref_lvl = 0;
            ref_col = 0;
        end else if (sol) begin
            ref_lvl = (ref_lvl == 2) ? 2 : ref_lvl + 1;
            ref_col = 0;
        end else begin
            ref_col++;
        end
        w        = '0;
        w.valid  = 1'b1;
        w.col    = col_t'(ref_col);
        w.cur    = data;
        w.up1_ok = (ref_lvl >= 1);
        w.up2_ok = (ref_lvl == 2);
        w.up1    = w.up1_ok ? row1[ref_col] : '0;
        w.up2    = w.up2_ok ? row2[ref_col] : '0;
        row2[ref_col] = row1[ref_col];
        row1[ref_col] = data;
        exp_q.push_back(w);
    endtask

    task automatic send_beat(input bit sof, input bit sol, input pixel_t data);
        pixel_beat_t b;
        b       = '0;
        b.valid = 1'b1;
        b.sof   = sof;
        b.sol   = sol | sof;
        b.data  = data;
        @(posedge rd_clk);
        s_beat <= b;
        predict_window(sof, sol | sof, data);
        in_cnt++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge rd_clk);
            s_beat <= '0;
        end
    endtask

    // one line of random pixels, optional random idle gaps
    task automatic send_line(input bit sof, input int len, input int max_gap);
        pixel_t data;
        int     gap;
        for (int i = 0; i < len; i++) begin
            data = pixel_t'($random(seed));
            send_beat(sof && (i == 0), i == 0, data);
            if (max_gap > 0) begin
                gap = $unsigned($random(seed)) % (max_gap + 1);
                idle(gap);
            end
        end
    endtask

    task automatic wait_windows(input int timeout);
        int n;
        n = 0;
        idle(1);
        while (exp_q.size() != 0 && n < timeout) begin
            @(posedge rd_clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("no window arrived for %0d pending beats", exp_q.size());
            exp_q.delete();
            beat_q.delete();
        end
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic test_reset_state();
        repeat (10) begin
            @(negedge rd_clk);
            if (m_win.valid !== 1'b0) begin
                errors++;
                $display("FAILED at %0t: m_win.valid expected 0, got %b", $time, m_win.valid);
            end
        end
        @(posedge rd_clk);
        reset <= 1'b0;
        repeat (8) begin
            @(negedge rd_clk);
            if (m_win.valid !== 1'b0) begin
                errors++;
                $display("FAILED at %0t: m_win.valid expected 0, got %b", $time, m_win.valid);
            end
        end
    endtask

    task automatic test_first_lines();
        send_line(1'b1, 16, 0);
        send_line(1'b0, 16, 0);
        wait_windows(100);
    endtask

    task automatic test_steady_state();
        send_line(1'b1, 16, 0);
        repeat (5) begin
            send_line(1'b0, 16, 0);
        end
        wait_windows(100);
    endtask

    task automatic test_latency_gaps();
        int start_in;
        int start_win;
        start_in  = in_cnt;
        start_win = win_cnt;
        send_line(1'b1, 16, 3);
        repeat (3) begin
            send_line(1'b0, 16, 3);
        end
        wait_windows(300);
        // nothing more may trail the last window
        idle(10);
        if (in_cnt - start_in != win_cnt - start_win) begin
            errors++;
            $display("%0d beats gave %0d windows", in_cnt - start_in, win_cnt - start_win);
        end
    endtask

    // sof arrives right after a line, RAM still holds the old frame
    task automatic test_new_frame();
        send_line(1'b1, 16, 0);
        send_line(1'b0, 16, 0);
        send_line(1'b0, 16, 0);
        send_line(1'b1, 16, 0);
        send_line(1'b0, 16, 0);
        send_line(1'b0, 16, 0);
        wait_windows(100);
    endtask

    task automatic test_line_edges();
        send_line(1'b1, `LB_MIN_COLS, 0);
        repeat (3) begin
            send_line(1'b0, `LB_MIN_COLS, 0);
        end
        send_line(1'b1, `LB_MAX_COLS, 0);
        repeat (2) begin
            send_line(1'b0, `LB_MAX_COLS, 0);
        end
        wait_windows(300);
    endtask

    initial begin
        rd_clk  = 1'b0;
        reset   = 1'b1;
        s_beat  = '0;
        errors  = 0;
        neg_cnt = 0;
        in_cnt  = 0;
        win_cnt = 0;
        ref_col = 0;
        ref_lvl = 0;

        test_reset_state();
        test_first_lines();
        test_steady_state();
        test_latency_gaps();
        test_new_frame();
        test_line_edges();
        idle(10);

        $display("errors: %0d, beats: %0d, windows: %0d", errors, in_cnt, win_cnt);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
video_pkg.sv
window_pkg.sv
ram_simple_dualport.sv
line_read_ctrl.sv
window_assembler.sv
vertical_window_top.sv
tb_vertical_window.sv
